// File: logic/dcr_pkg.sv
package dcr_pkg;

    // ########################################
    // device configuration registers
    // ########################################

    // number of compute clusters that share the memory port.
    localparam int num_clusters = 2;

    localparam int dcr_addr_width = 4;
    localparam int dcr_data_width = 32;

    typedef enum logic [dcr_addr_width-1:0] {
        dcr_base   = 4'h1,
        dcr_count  = 4'h2,
        dcr_addend = 4'h3
    } dcr_addr_e;

    // kernel settings seen by every cluster.
    // base is a word address, count is the number of words in the buffer.
    typedef struct packed {
        logic [15:0]               base;
        logic [15:0]               count;
        logic [dcr_data_width-1:0] addend;
    } kernel_cfg_t;

endpackage

// File: logic/mem_pkg.sv
package mem_pkg;

    // ########################################
    // memory bus layout
    // ########################################

    localparam int mem_addr_width = 16;
    localparam int mem_data_width = 32;

    // the low tag bits select a read slot inside a cluster.
    localparam int cluster_tag_width = 2;
    localparam int cluster_slots     = 2 ** cluster_tag_width;

    // the upper tag bits carry the cluster index on the shared port.
    localparam int cluster_id_width =
        (dcr_pkg::num_clusters > 1) ? $clog2(dcr_pkg::num_clusters) : 1;
    localparam int mem_tag_width = cluster_tag_width + cluster_id_width;

    typedef logic [cluster_tag_width-1:0] cluster_tag_t;
    typedef logic [cluster_id_width-1:0]  cluster_id_t;

    typedef struct packed {
        logic                      rw;
        logic [mem_addr_width-1:0] addr;
        logic [mem_data_width-1:0] data;
        logic [mem_tag_width-1:0]  tag;
    } mem_req_t;

    typedef struct packed {
        logic [mem_data_width-1:0] data;
        logic [mem_tag_width-1:0]  tag;
    } mem_rsp_t;

    typedef struct packed {
        logic                      rw;
        logic [mem_addr_width-1:0] addr;
        logic [mem_data_width-1:0] data;
        cluster_tag_t              tag;
    } cluster_req_t;

    typedef struct packed {
        logic [mem_data_width-1:0] data;
        cluster_tag_t              tag;
    } cluster_rsp_t;

endpackage

// File: logic/dcr_regs.sv
`timescale 1ns/100ps

module dcr_regs (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wr_valid,
    input  dcr_pkg::dcr_addr_e                  wr_addr,
    input  logic [dcr_pkg::dcr_data_width-1:0]  wr_data,
    output logic                                wr_ready,
    input  logic                                busy,
    output dcr_pkg::kernel_cfg_t                cfg
);

    logic wr_fire;

    // the configuration is frozen while a kernel runs.
    assign wr_ready = ~busy;
    assign wr_fire  = wr_valid & wr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg <= '0;
        end else if (wr_fire) begin
            case (wr_addr)
                dcr_pkg::dcr_base: begin
                    cfg.base <= wr_data[$bits(cfg.base)-1:0];
                end
                dcr_pkg::dcr_count: begin
                    cfg.count <= wr_data[$bits(cfg.count)-1:0];
                end
                dcr_pkg::dcr_addend: begin
                    cfg.addend <= wr_data;
                end
                default: begin
                    // unknown addresses are accepted and dropped.
                end
            endcase
        end
    end

endmodule

// File: logic/compute_cluster.sv
`timescale 1ns/100ps

module compute_cluster (
    input  logic                  clk,
    input  logic                  rst,
    input  mem_pkg::cluster_id_t  cluster_id,
    input  dcr_pkg::kernel_cfg_t  cfg,
    input  logic                  start,
    output logic                  busy,
    output logic                  req_valid,
    output mem_pkg::cluster_req_t req,
    input  logic                  req_ready,
    input  logic                  rsp_valid,
    input  mem_pkg::cluster_rsp_t rsp
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_drain
    } state_e;

    typedef enum logic [1:0] {
        slot_free,
        slot_reading,
        slot_write
    } slot_e;

    // one bit wider than count so the last step cannot wrap.
    typedef logic [16:0] idx_t;

    state_e state;
    idx_t   next_idx;

    slot_e                               slot_state [mem_pkg::cluster_slots];
    logic [mem_pkg::mem_addr_width-1:0]  slot_addr  [mem_pkg::cluster_slots];
    logic [mem_pkg::mem_data_width-1:0]  slot_data  [mem_pkg::cluster_slots];

    logic                  wr_found;
    logic                  free_found;
    logic                  all_free;
    mem_pkg::cluster_tag_t wr_slot;
    mem_pkg::cluster_tag_t free_slot;

    logic                  hold;
    logic                  hold_write;
    mem_pkg::cluster_tag_t hold_slot;

    logic                               words_left;
    logic                               do_write;
    mem_pkg::cluster_tag_t              sel_slot;
    logic [mem_pkg::mem_addr_width-1:0] rd_addr;
    logic                               fire;

    // ########################################
    // slot scan and request choice
    // ########################################

    // scanning downwards leaves the lowest matching slot selected.
    always_comb begin
        wr_found   = 1'b0;
        wr_slot    = '0;
        free_found = 1'b0;
        free_slot  = '0;
        all_free   = 1'b1;
        for (int s = mem_pkg::cluster_slots - 1; s >= 0; s--) begin
            if (slot_state[s] == slot_write) begin
                wr_found = 1'b1;
                wr_slot  = mem_pkg::cluster_tag_t'(s);
            end
            if (slot_state[s] == slot_free) begin
                free_found = 1'b1;
                free_slot  = mem_pkg::cluster_tag_t'(s);
            end else begin
                all_free = 1'b0;
            end
        end
    end

    assign busy       = (state != st_idle);
    assign words_left = (next_idx < idx_t'(cfg.count));
    assign rd_addr    = cfg.base + next_idx[mem_pkg::mem_addr_width-1:0];

    // a stalled request keeps its choice, so a response arriving
    // meanwhile cannot swap a read for a write.
    assign do_write = hold ? hold_write : wr_found;
    assign sel_slot = hold ? hold_slot : (wr_found ? wr_slot : free_slot);

    assign req_valid = hold | (busy & (wr_found | (words_left & free_found)));
    assign fire      = req_valid & req_ready;

    always_comb begin
        req.rw   = do_write;
        req.tag  = sel_slot;
        req.addr = do_write ? slot_addr[sel_slot] : rd_addr;
        req.data = do_write ? slot_data[sel_slot] : '0;
    end

    // ########################################
    // control state
    // ########################################

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            next_idx <= '0;
            hold     <= 1'b0;
            for (int s = 0; s < mem_pkg::cluster_slots; s++) begin
                slot_state[s] <= slot_free;
            end
        end else begin
            hold <= req_valid & ~req_ready;

            case (state)
                st_idle: begin
                    if (start) begin
                        state    <= st_run;
                        next_idx <= idx_t'(cluster_id);
                    end
                end
                st_run: begin
                    if (!words_left) begin
                        state <= all_free ? st_idle : st_drain;
                    end
                end
                st_drain: begin
                    if (all_free) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase

            if (fire) begin
                if (do_write) begin
                    slot_state[sel_slot] <= slot_free;
                end else begin
                    slot_state[sel_slot] <= slot_reading;
                    next_idx <= next_idx + idx_t'(dcr_pkg::num_clusters);
                end
            end

            // responses only ever land in reading slots.
            if (rsp_valid) begin
                slot_state[rsp.tag] <= slot_write;
            end
        end
    end

    always_ff @(posedge clk) begin
        hold_write <= do_write;
        hold_slot  <= sel_slot;
        if (fire && !do_write) begin
            slot_addr[sel_slot] <= rd_addr;
        end
        if (rsp_valid) begin
            slot_data[rsp.tag] <= rsp.data + cfg.addend;
        end
    end

endmodule

// File: logic/mem_mux.sv
`timescale 1ns/100ps

module mem_mux (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic [dcr_pkg::num_clusters-1:0]                   in_valid,
    input  mem_pkg::cluster_req_t [dcr_pkg::num_clusters-1:0]  in_req,
    output logic [dcr_pkg::num_clusters-1:0]                   in_ready,
    output logic                                               out_valid,
    output mem_pkg::mem_req_t                                  out_req,
    input  logic                                               out_ready,
    input  logic                                               rsp_valid,
    input  mem_pkg::mem_rsp_t                                  rsp,
    output logic [dcr_pkg::num_clusters-1:0]                   in_rsp_valid,
    output mem_pkg::cluster_rsp_t [dcr_pkg::num_clusters-1:0]  in_rsp
);

    mem_pkg::cluster_id_t rr_ptr;
    mem_pkg::cluster_id_t grant_idx;
    mem_pkg::cluster_id_t rr_idx;
    logic                 rr_found;

    // a stalled transfer keeps its winner until it completes.
    logic                 locked;
    mem_pkg::cluster_id_t locked_idx;

    logic                 fire;
    mem_pkg::cluster_id_t rsp_id;

    // ########################################
    // request arbitration
    // ########################################

    // the smallest offset from the pointer wins, so scan offsets downwards.
    always_comb begin
        int c;
        rr_found = 1'b0;
        rr_idx   = rr_ptr;
        for (int k = dcr_pkg::num_clusters - 1; k >= 0; k--) begin
            c = (int'(rr_ptr) + k) % dcr_pkg::num_clusters;
            if (in_valid[c]) begin
                rr_found = 1'b1;
                rr_idx   = mem_pkg::cluster_id_t'(c);
            end
        end
    end

    assign grant_idx = locked ? locked_idx : rr_idx;
    assign out_valid = locked ? in_valid[locked_idx] : rr_found;
    assign fire      = out_valid & out_ready;

    always_comb begin
        out_req.rw   = in_req[grant_idx].rw;
        out_req.addr = in_req[grant_idx].addr;
        out_req.data = in_req[grant_idx].data;
        out_req.tag  = {grant_idx, in_req[grant_idx].tag};
        in_ready     = '0;
        in_ready[grant_idx] = out_valid & out_ready;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
            locked <= 1'b0;
        end else begin
            locked <= out_valid & ~out_ready;
            if (fire) begin
                rr_ptr <= mem_pkg::cluster_id_t'((int'(grant_idx) + 1) % dcr_pkg::num_clusters);
            end
        end
    end

    always_ff @(posedge clk) begin
        locked_idx <= grant_idx;
    end

    // ########################################
    // response routing
    // ########################################

    assign rsp_id = rsp.tag[mem_pkg::mem_tag_width-1:mem_pkg::cluster_tag_width];

    always_comb begin
        for (int i = 0; i < dcr_pkg::num_clusters; i++) begin
            in_rsp_valid[i] = rsp_valid && (int'(rsp_id) == i);
            in_rsp[i].data  = rsp.data;
            in_rsp[i].tag   = rsp.tag[mem_pkg::cluster_tag_width-1:0];
        end
    end

endmodule

// File: logic/gpu_top.sv
`timescale 1ns/100ps

module gpu_top (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                dcr_wr_valid,
    input  dcr_pkg::dcr_addr_e                  dcr_wr_addr,
    input  logic [dcr_pkg::dcr_data_width-1:0]  dcr_wr_data,
    output logic                                dcr_wr_ready,

    input  logic                                start,
    output logic                                busy,

    output logic                                mem_req_valid,
    output mem_pkg::mem_req_t                   mem_req,
    input  logic                                mem_req_ready,

    input  logic                                mem_rsp_valid,
    input  mem_pkg::mem_rsp_t                   mem_rsp
);

    dcr_pkg::kernel_cfg_t cfg;

    logic [dcr_pkg::num_clusters-1:0] cluster_busy;
    logic [dcr_pkg::num_clusters-1:0] cluster_req_valid;
    logic [dcr_pkg::num_clusters-1:0] cluster_req_ready;
    logic [dcr_pkg::num_clusters-1:0] cluster_rsp_valid;
    logic                             cluster_start;

    mem_pkg::cluster_req_t [dcr_pkg::num_clusters-1:0] cluster_req;
    mem_pkg::cluster_rsp_t [dcr_pkg::num_clusters-1:0] cluster_rsp;

    assign busy = |cluster_busy;

    // a start pulse while any cluster still runs is dropped for all of them.
    assign cluster_start = start & ~busy;

    dcr_regs u_dcr_regs (
        .clk      (clk),
        .rst      (rst),
        .wr_valid (dcr_wr_valid),
        .wr_addr  (dcr_wr_addr),
        .wr_data  (dcr_wr_data),
        .wr_ready (dcr_wr_ready),
        .busy     (busy),
        .cfg      (cfg)
    );

    // ########################################
    // compute clusters
    // ########################################

    for (genvar i = 0; i < dcr_pkg::num_clusters; i++) begin : g_cluster
        compute_cluster u_cluster (
            .clk        (clk),
            .rst        (rst),
            .cluster_id (mem_pkg::cluster_id_t'(i)),
            .cfg        (cfg),
            .start      (cluster_start),
            .busy       (cluster_busy[i]),
            .req_valid  (cluster_req_valid[i]),
            .req        (cluster_req[i]),
            .req_ready  (cluster_req_ready[i]),
            .rsp_valid  (cluster_rsp_valid[i]),
            .rsp        (cluster_rsp[i])
        );
    end

    mem_mux u_mem_mux (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (cluster_req_valid),
        .in_req       (cluster_req),
        .in_ready     (cluster_req_ready),
        .out_valid    (mem_req_valid),
        .out_req      (mem_req),
        .out_ready    (mem_req_ready),
        .rsp_valid    (mem_rsp_valid),
        .rsp          (mem_rsp),
        .in_rsp_valid (cluster_rsp_valid),
        .in_rsp       (cluster_rsp)
    );

endmodule

// File: dv/clk_gen.sv
`timescale 1ns/100ps

module clk_gen (
    output logic clk
);

    // 4 ns period, first rising edge at 2 ns.
    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

endmodule

// File: dv/gpu_top_checker.sv
`timescale 1ns/100ps

module gpu_top_checker (
    input logic              clk,
    input logic              rst,
    input logic              busy,
    input logic              dcr_wr_ready,
    input logic              mem_req_valid,
    input logic              mem_req_ready,
    input mem_pkg::mem_req_t mem_req
);

    // a stalled request must reappear unchanged on the next cycle.
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req)))
        else $error("memory request changed or dropped while stalled");

    a_dcr_blocked: assert property (@(posedge clk) disable iff (rst)
        busy |-> !dcr_wr_ready)
        else $error("DCR port ready while a kernel is running");

    a_reset_req: assert property (@(posedge clk)
        (rst && $past(rst)) |-> !mem_req_valid)
        else $error("memory request valid during reset");

    a_reset_busy: assert property (@(posedge clk)
        (rst && $past(rst)) |-> !busy)
        else $error("busy high during reset");

endmodule

bind gpu_top gpu_top_checker u_checker (
    .clk           (clk),
    .rst           (rst),
    .busy          (busy),
    .dcr_wr_ready  (dcr_wr_ready),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req       (mem_req)
);

// File: dv/gpu_top_tb.sv
`timescale 1ns/100ps

module gpu_top_tb;

    localparam int mem_words    = 1024;
    localparam int num_rows     = 7;
    localparam int reset_cycles = 8;

    typedef struct packed {
        logic [15:0] base;
        logic [15:0] count;
        logic [31:0] addend;
        logic [7:0]  stall_percent;
    } row_t;

    // odd counts give the two clusters unequal shares.
    localparam row_t rows [num_rows] = '{
        '{base: 16'd16,   count: 16'd10, addend: 32'h0000_0005, stall_percent: 8'd0},
        '{base: 16'd100,  count: 16'd7,  addend: 32'hffff_fff0, stall_percent: 8'd20},
        '{base: 16'd300,  count: 16'd33, addend: 32'h1234_5678, stall_percent: 8'd70},
        '{base: 16'd500,  count: 16'd0,  addend: 32'h0000_0009, stall_percent: 8'd0},
        '{base: 16'd600,  count: 16'd1,  addend: 32'h0000_0003, stall_percent: 8'd50},
        '{base: 16'd700,  count: 16'd21, addend: 32'h8000_0001, stall_percent: 8'd85},
        '{base: 16'd1000, count: 16'd24, addend: 32'h0000_0001, stall_percent: 8'd40}
    };

    logic                               clk;
    logic                               rst;
    logic                               dcr_wr_valid;
    dcr_pkg::dcr_addr_e                 dcr_wr_addr;
    logic [dcr_pkg::dcr_data_width-1:0] dcr_wr_data;
    logic                               dcr_wr_ready;
    logic                               start;
    logic                               busy;
    logic                               mem_req_valid;
    mem_pkg::mem_req_t                  mem_req;
    logic                               mem_req_ready = 1'b0;
    logic                               mem_rsp_valid = 1'b0;
    mem_pkg::mem_rsp_t                  mem_rsp = '0;

    // memory model state.
    logic [31:0]                       mem_array [mem_words];
    int                                write_hits [mem_words];
    logic [mem_pkg::mem_tag_width-1:0] pend_tag [$];
    logic [31:0]                       pend_data [$];
    int                                pend_due [$];
    logic [31:0]                       lcg_state = 32'hc044;
    logic                              mem_filled = 1'b0;
    int                                req_count = 0;
    int                                model_fail_count = 0;

    // reference state kept by the stimulus process.
    logic [31:0] ref_mem [mem_words];
    int          exp_hits [mem_words];
    int          win_lo = 0;
    int          win_hi = 0;
    int          stall_percent = 0;
    int          mismatch_count = 0;
    int          check_fail_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 1;

    clk_gen u_clk_gen (.clk(clk));

    gpu_top uut (
        .clk           (clk),
        .rst           (rst),
        .dcr_wr_valid  (dcr_wr_valid),
        .dcr_wr_addr   (dcr_wr_addr),
        .dcr_wr_data   (dcr_wr_data),
        .dcr_wr_ready  (dcr_wr_ready),
        .start         (start),
        .busy          (busy),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(int n);
        logic [31:0] v;
        v = lcg_next();
        return int'(v[30:16]) % n;
    endfunction

    // ########################################
    // memory model
    // ########################################

    always @(posedge clk) begin : memory_model
        int addr;
        int pick;
        if (rst) begin
            if (!mem_filled) begin
                for (int a = 0; a < mem_words; a++) begin
                    mem_array[a] = lcg_next();
                end
                mem_filled = 1'b1;
            end
            mem_req_ready <= 1'b0;
            mem_rsp_valid <= 1'b0;
        end else begin
            if (mem_req_valid && mem_req_ready) begin
                req_count = req_count + 1;
                addr = int'(mem_req.addr);
                if (addr < win_lo || addr >= win_hi) begin
                    $display("time %0t: memory access to address %0d lies outside the buffer",
                             $time, addr);
                    model_fail_count = model_fail_count + 1;
                end else if (mem_req.rw) begin
                    mem_array[addr] = mem_req.data;
                    write_hits[addr] = write_hits[addr] + 1;
                end else begin
                    pend_tag.push_back(mem_req.tag);
                    pend_data.push_back(mem_array[addr]);
                    pend_due.push_back(cycle_count + 1 + rand_below(8));
                end
            end

            // a random pending entry is returned once its delay has run out.
            mem_rsp_valid <= 1'b0;
            if (pend_tag.size() > 0) begin
                pick = rand_below(pend_tag.size());
                if (pend_due[pick] <= cycle_count) begin
                    mem_rsp_valid <= 1'b1;
                    mem_rsp.data  <= pend_data[pick];
                    mem_rsp.tag   <= pend_tag[pick];
                    pend_tag.delete(pick);
                    pend_data.delete(pick);
                    pend_due.delete(pick);
                end
            end
            mem_req_ready <= (rand_below(100) >= stall_percent);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("the run timed out after %0d cycles", cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    // ########################################
    // stimulus and checks
    // ########################################

    task automatic dcr_write(input dcr_pkg::dcr_addr_e addr, input logic [31:0] data);
        dcr_wr_valid <= 1'b1;
        dcr_wr_addr  <= addr;
        dcr_wr_data  <= data;
        @(posedge clk);
        while (dcr_wr_ready !== 1'b1) begin
            @(posedge clk);
        end
        dcr_wr_valid <= 1'b0;
    endtask

    task automatic run_row(input row_t r);
        int reqs_before;
        win_lo = int'(r.base);
        win_hi = int'(r.base) + int'(r.count);
        stall_percent = int'(r.stall_percent);
        dcr_write(dcr_pkg::dcr_base, 32'(r.base));
        dcr_write(dcr_pkg::dcr_count, 32'(r.count));
        dcr_write(dcr_pkg::dcr_addend, r.addend);
        reqs_before = req_count;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        if (busy !== 1'b1) begin
            $display("Mismatch at %0t: busy expected 1, got %b", $time, busy);
            mismatch_count++;
        end
        // a second configuration and start must not reach the running kernel.
        if (r.count > 16'd4) begin
            dcr_wr_valid <= 1'b1;
            dcr_wr_addr  <= dcr_pkg::dcr_addend;
            dcr_wr_data  <= ~r.addend;
            start        <= 1'b1;
            @(posedge clk);
            if (dcr_wr_ready !== 1'b0) begin
                $display("Mismatch at %0t: dcr_wr_ready expected 0, got %b",
                         $time, dcr_wr_ready);
                mismatch_count++;
            end
            dcr_wr_valid <= 1'b0;
            start        <= 1'b0;
        end
        while (busy !== 1'b0) begin
            @(posedge clk);
        end
        @(posedge clk);
        if (pend_tag.size() != 0) begin
            $display("time %0t: %0d reads left unanswered", $time, pend_tag.size());
            check_fail_count++;
        end
        if (req_count - reqs_before != 2 * int'(r.count)) begin
            $display("Mismatch at %0t: request count expected %0d, got %0d",
                     $time, 2 * int'(r.count), req_count - reqs_before);
            mismatch_count++;
        end
        for (int a = win_lo; a < win_hi; a++) begin
            ref_mem[a] = ref_mem[a] + r.addend;
            exp_hits[a] = exp_hits[a] + 1;
        end
        for (int a = 0; a < mem_words; a++) begin
            if (mem_array[a] !== ref_mem[a]) begin
                $display("Mismatch at %0t: mem[%0d] expected %h, got %h",
                         $time, a, ref_mem[a], mem_array[a]);
                mismatch_count++;
            end
            if (write_hits[a] != exp_hits[a]) begin
                $display("time %0t: address %0d written %0d times instead of %0d",
                         $time, a, write_hits[a], exp_hits[a]);
                check_fail_count++;
            end
        end
    endtask

    initial begin
        rst          <= 1'b1;
        dcr_wr_valid <= 1'b0;
        dcr_wr_addr  <= dcr_pkg::dcr_base;
        dcr_wr_data  <= '0;
        start        <= 1'b0;
        cycle_limit  = reset_cycles;
        for (int i = 0; i < num_rows; i++) begin
            cycle_limit += int'(rows[i].count) * 40 + 200;
        end

        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        if (busy !== 1'b0 || mem_req_valid !== 1'b0 || dcr_wr_ready !== 1'b1) begin
            $display("Mismatch at %0t: busy/mem_req_valid/dcr_wr_ready expected 001, got %b%b%b",
                     $time, busy, mem_req_valid, dcr_wr_ready);
            mismatch_count++;
        end
        for (int a = 0; a < mem_words; a++) begin
            ref_mem[a] = mem_array[a];
        end

        for (int i = 0; i < num_rows; i++) begin
            run_row(rows[i]);
        end

        $display("errors: %0d mismatches, %0d other failures",
                 mismatch_count, check_fail_count + model_fail_count);
        if (mismatch_count == 0 && check_fail_count + model_fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: gpu_top.f
logic/dcr_pkg.sv
logic/mem_pkg.sv
logic/dcr_regs.sv
logic/compute_cluster.sv
logic/mem_mux.sv
logic/gpu_top.sv
dv/clk_gen.sv
dv/gpu_top_checker.sv
dv/gpu_top_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module gpu_top_tb -f gpu_top.f \
    -Mdir obj_dir -o gpu_top_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/gpu_top_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* PASS \*\*' sim.log; then
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi
